// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ascon_fetch -f sources.f

./obj_dir/Vtb_ascon_fetch > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi

// ==== sources.f ====
verilog/ascon_fetch_pkg.sv
verilog/ascon_round.sv
verilog/keystream_engine.sv
verilog/patch_pipeline.sv
verilog/fetch_decryptor.sv
verilog/ascon_fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_ascon_fetch.sv

// ==== testbench/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
    input  logic                        clk_core_slow_i,
    input  logic                        rst_ni,
    input  logic                        req_ready_i,
    input  ascon_fetch_pkg::fetch_rsp_t rsp_i,
    input  logic                        rsp_valid_i,
    input  logic                        rsp_ready_i,
    input  logic                        exp_valid_i,
    input  ascon_fetch_pkg::fetch_rsp_t exp_rsp_i,
    output int                          seen_o,
    output int                          errors_o
);
    import ascon_fetch_pkg::*;

    fetch_rsp_t exp_q[$];
    int         seen = 0;
    int         errors = 0;

    assign seen_o   = seen;
    assign errors_o = errors;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    always @(posedge clk_core_slow_i) begin
        if (exp_valid_i) begin
            exp_q.push_back(exp_rsp_i);
        end
    end

    // Handshakes are read mid-cycle where both sides are settled
    always @(negedge clk_core_slow_i) begin
        fetch_rsp_t want;
        if (rst_ni && rsp_valid_i && !rsp_ready_i && req_ready_i) begin
            $display("Request channel was ready while a response was held");
            errors++;
        end
        if (rst_ni && rsp_valid_i && rsp_ready_i) begin
            seen++;
            if (exp_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                errors++;
            end else begin
                want = exp_q.pop_front();
                compare_field("plain", rsp_i.plain, want.plain);
                compare_field("redirect_hit", 32'(rsp_i.redirect_hit),
                              32'(want.redirect_hit));
                compare_field("redirect_addr", 32'(rsp_i.redirect_addr),
                              32'(want.redirect_addr));
                compare_field("redirect_tag", 32'(rsp_i.redirect_tag),
                              32'(want.redirect_tag));
            end
        end
    end

endmodule

// ==== testbench/tb_ascon_fetch.sv ====
`timescale 1ns/1ps

module tb_ascon_fetch;
    import ascon_fetch_pkg::*;

    logic         clk_core_slow_i = 1'b0;
    logic         rst_ni;
    fetch_req_t   req_i;
    logic         req_valid_i;
    logic         req_ready_o;
    fetch_rsp_t   rsp_o;
    logic         rsp_valid_o;
    logic         rsp_ready_i;
    logic         exp_valid = 1'b0;
    fetch_rsp_t   exp_rsp;
    int           seen;
    int           errors;
    int           accepted = 0;
    int           tb_errors = 0;
    int           failed_tests = 0;
    logic         stall_en = 1'b0;
    logic [31:0]  lfsr = 32'd24;
    ascon_state_t model_state = STATE_INIT;
    patch_t       model_if = '0;
    patch_t       model_id = '0;
    patch_t       model_ex = '0;

    always #2 clk_core_slow_i = ~clk_core_slow_i;

    ascon_fetch_top i_ascon_fetch_top (.*);

    fetch_checker i_fetch_checker (
        .clk_core_slow_i (clk_core_slow_i),
        .rst_ni          (rst_ni),
        .req_ready_i     (req_ready_o),
        .rsp_i           (rsp_o),
        .rsp_valid_i     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .exp_valid_i     (exp_valid),
        .exp_rsp_i       (exp_rsp),
        .seen_o          (seen),
        .errors_o        (errors)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic logic [63:0] rot(input logic [63:0] x, input int n);
        logic [127:0] w;
        w = {x, x} >> n;
        return w[63:0];
    endfunction

    // Round r of twelve with the S-box in algebraic normal form
    function automatic ascon_state_t model_round(input ascon_state_t s, input int r);
        logic [63:0]  x0, x1, x2, x3, x4;
        ascon_state_t t;
        x0 = s[0];
        x1 = s[1];
        x2 = s[2] ^ {56'd0, 4'(15 - r), 4'(r)};
        x3 = s[3];
        x4 = s[4];
        t[0] = (x4 & x1) ^ x3 ^ (x2 & x1) ^ x2 ^ (x1 & x0) ^ x1 ^ x0;
        t[1] = x4 ^ (x3 & x2) ^ (x3 & x1) ^ x3 ^ (x2 & x1) ^ x2 ^ x1 ^ x0;
        t[2] = (x4 & x3) ^ x4 ^ x2 ^ x1 ^ ~64'd0;
        t[3] = (x4 & x0) ^ x4 ^ (x3 & x0) ^ x3 ^ x2 ^ x1 ^ x0;
        t[4] = (x4 & x1) ^ x4 ^ x3 ^ (x1 & x0) ^ x1;
        t[0] = t[0] ^ rot(t[0], 19) ^ rot(t[0], 28);
        t[1] = t[1] ^ rot(t[1], 61) ^ rot(t[1], 39);
        t[2] = t[2] ^ rot(t[2], 1) ^ rot(t[2], 6);
        t[3] = t[3] ^ rot(t[3], 10) ^ rot(t[3], 17);
        t[4] = t[4] ^ rot(t[4], 7) ^ rot(t[4], 41);
        return t;
    endfunction

    function automatic fetch_req_t random_req();
        fetch_req_t r;
        r.addr   = 16'(take_bits(16));
        r.cipher = take_bits(32);
        for (int i = 0; i < 10; i++) begin
            r.patch[i*32 +: 32] = take_bits(32);
        end
        r.init_state  = 1'b0;
        r.apply_patch = take_bits(1) != 32'd0;
        r.sel_patch   = patch_sel_e'(2'(take_bits(2)));
        return r;
    endfunction

    // Mode 0 misses the target, 1 hits once, 2 hits in two entries
    function automatic patch_t redirect_patch(input logic [15:0] target, input int mode);
        patch_t p;
        int     a;
        int     b;
        p.tag = (take_bits(1) != 32'd0) ? REDIR_TAG : 12'(take_bits(12));
        for (int i = 0; i < NUM_REDIRECTS; i++) begin
            p.entries[i].src_word = 14'(take_bits(14));
            if (p.entries[i].src_word == target[15:2]) begin
                p.entries[i].src_word ^= 14'h1;
            end
            p.entries[i].dst_word = 14'(take_bits(14));
        end
        a = int'(take_bits(4)) % NUM_REDIRECTS;
        b = (a + 1 + int'(take_bits(3))) % NUM_REDIRECTS;
        if (mode > 0) begin
            p.entries[a].src_word = target[15:2];
        end
        if (mode > 1) begin
            p.entries[b].src_word = target[15:2];
        end
        return p;
    endfunction

    // Reference model for one accepted request
    task automatic step_model(input fetch_req_t r, output fetch_rsp_t e);
        ascon_state_t st;
        patch_t       p;
        case (r.sel_patch)
            PATCH_IF: p = model_if;
            PATCH_ID: p = model_id;
            PATCH_EX: p = model_ex;
            default:  p = '0;
        endcase
        st = r.init_state ? STATE_INIT : model_state;
        if (r.apply_patch) begin
            st = st ^ p;
        end
        e = '0;
        e.plain = st[0][63:32] ^ r.cipher;
        for (int i = 0; i < NUM_REDIRECTS; i++) begin
            if (!e.redirect_hit && model_id.entries[i].src_word == r.addr[15:2]) begin
                e.redirect_hit  = 1'b1;
                e.redirect_addr = {model_id.entries[i].dst_word, 2'b00};
            end
        end
        e.redirect_tag = (model_id.tag == 12'hfff);
        st[0][63:32] = r.cipher;
        for (int k = 6; k < 12; k++) begin
            st = model_round(st, k);
        end
        model_state = st;
        model_ex    = model_id;
        model_id    = model_if;
        model_if    = r.patch;
    endtask

    // Model steps on each handshake seen mid-cycle
    always @(negedge clk_core_slow_i) begin
        fetch_rsp_t e;
        exp_valid <= 1'b0;
        if (rst_ni && req_valid_i && req_ready_o) begin
            step_model(req_i, e);
            exp_rsp   <= e;
            exp_valid <= 1'b1;
            accepted++;
        end
    end

    task automatic next_cycle();
        @(posedge clk_core_slow_i);
        #0.5;
        rsp_ready_i = stall_en ? (take_bits(2) != 32'd0) : 1'b1;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic send_req(input fetch_req_t r);
        int   wait_cnt;
        logic fired;
        if (stall_en) begin
            repeat (int'(take_bits(2))) next_cycle();
        end
        req_i       = r;
        req_valid_i = 1'b1;
        fired       = 1'b0;
        wait_cnt    = 0;
        while (!fired && wait_cnt < 64) begin
            @(negedge clk_core_slow_i);
            fired = req_ready_o;
            next_cycle();
            wait_cnt++;
        end
        if (!fired) begin
            abort_on_timeout("a request was never accepted");
        end else begin
            req_valid_i = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int base);
        int wait_cnt;
        wait_cnt = 0;
        while ((seen != accepted || rsp_valid_o) && wait_cnt < 400) begin
            next_cycle();
            wait_cnt++;
        end
        if (seen != accepted || rsp_valid_o) begin
            abort_on_timeout({name, ": outstanding responses never arrived"});
        end else if (errors + tb_errors == base) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors + tb_errors - base);
            failed_tests++;
        end
    endtask

    initial begin
        fetch_req_t  r;
        logic [15:0] addrs [0:23];
        int          base;
        rst_ni      = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b1;
        repeat (2) @(posedge clk_core_slow_i);
        #0.5;
        rst_ni = 1'b1;

        base = 0;
        if (rsp_valid_o !== 1'b0) begin
            $display("ERROR rsp_valid_o got %h expected 0", rsp_valid_o);
            tb_errors++;
        end
        if (req_ready_o !== 1'b1) begin
            $display("ERROR req_ready_o got %h expected 1", req_ready_o);
            tb_errors++;
        end
        r = random_req();
        r.init_state  = 1'b1;
        r.apply_patch = 1'b0;
        send_req(r);
        finish_test("reset_and_init", base);

        base = errors + tb_errors;
        for (int k = 0; k < 20; k++) begin
            r = random_req();
            r.apply_patch = 1'b0;
            send_req(r);
        end
        finish_test("chaining", base);

        base = errors + tb_errors;
        for (int k = 0; k < 24; k++) begin
            r = random_req();
            r.sel_patch = patch_sel_e'(2'(k));
            send_req(r);
        end
        finish_test("patching", base);

        // Each ID patch targets the address fetched two requests later
        base = errors + tb_errors;
        for (int k = 0; k < 24; k++) begin
            addrs[k] = 16'(take_bits(16));
        end
        for (int k = 0; k < 22; k++) begin
            r = random_req();
            r.addr  = addrs[k];
            r.patch = redirect_patch(addrs[k + 2], k % 3);
            send_req(r);
        end
        finish_test("redirection", base);

        base = errors + tb_errors;
        stall_en = 1'b1;
        for (int k = 0; k < 30; k++) begin
            r = random_req();
            r.init_state = (take_bits(3) == 32'd0);
            send_req(r);
        end
        finish_test("back_pressure", base);
        stall_en = 1'b0;

        $display("Summary: %0d of 5 tests failed, %0d responses checked, %0d errors",
                 failed_tests, seen, errors + tb_errors);
        if (failed_tests == 0 && errors + tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog/ascon_fetch_pkg.sv ====
package ascon_fetch_pkg;

    localparam int ADDR_WIDTH       = 16;
    localparam int WORD_WIDTH       = 32;
    localparam int LANE_WIDTH       = 64;
    localparam int NUM_LANES        = 5;
    localparam int PATCH_WIDTH      = NUM_LANES * LANE_WIDTH;
    localparam int NUM_REDIRECTS    = 11;
    localparam int REDIR_ADDR_WIDTH = 14;
    localparam int REDIR_TAG_WIDTH  = 12;
    localparam int PB_ROUNDS        = 6;

    localparam logic [REDIR_TAG_WIDTH-1:0] REDIR_TAG = 12'hfff;

    // Last six constants of the twelve-round schedule
    localparam logic [0:PB_ROUNDS-1][7:0] ROUND_CONSTS = {
        8'h96, 8'h87, 8'h78, 8'h69, 8'h5a, 8'h4b
    };

    // Lane 0 sits in the most significant bits
    typedef logic [0:NUM_LANES-1][LANE_WIDTH-1:0] ascon_state_t;

    // State after keyed initialisation
    localparam ascon_state_t STATE_INIT = {
        64'h32def87181d97180,
        64'h5e08195f024d70a5,
        64'h470c5742d5b5e50e,
        64'hc9c0ab2425b50d55,
        64'h8dc8253a813db70c
    };

    typedef enum logic [1:0] {
        PATCH_NULL = 2'd0,
        PATCH_IF   = 2'd1,
        PATCH_ID   = 2'd2,
        PATCH_EX   = 2'd3
    } patch_sel_e;

    typedef enum logic {
        ENG_IDLE = 1'b0,
        ENG_RUN  = 1'b1
    } engine_state_e;

    typedef struct packed {
        logic [REDIR_ADDR_WIDTH-1:0] src_word;
        logic [REDIR_ADDR_WIDTH-1:0] dst_word;
    } redirect_entry_t;

    // Entry 0 directly below the tag
    typedef struct packed {
        logic [REDIR_TAG_WIDTH-1:0]             tag;
        redirect_entry_t [0:NUM_REDIRECTS-1]    entries;
    } patch_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] cipher;
        patch_t                patch;
        logic                  init_state;
        logic                  apply_patch;
        patch_sel_e            sel_patch;
    } fetch_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] plain;
        logic                  redirect_hit;
        logic [ADDR_WIDTH-1:0] redirect_addr;
        logic                  redirect_tag;
    } fetch_rsp_t;

endpackage

// ==== verilog/ascon_fetch_top.sv ====
`timescale 1ns/1ps

module ascon_fetch_top (
    input  logic                        clk_core_slow_i,
    input  logic                        rst_ni,
    input  ascon_fetch_pkg::fetch_req_t req_i,
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    output ascon_fetch_pkg::fetch_rsp_t rsp_o,
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i
);
    import ascon_fetch_pkg::*;

    logic         accept;
    logic         engine_busy;
    ascon_state_t engine_state;
    ascon_state_t absorb_state;
    patch_t       sel_patch;
    fetch_rsp_t   redirect;

    patch_pipeline i_patch_pipeline (
        .clk_core_slow_i (clk_core_slow_i),
        .rst_ni          (rst_ni),
        .shift_i         (accept),
        .patch_i         (req_i.patch),
        .sel_patch_i     (req_i.sel_patch),
        .addr_i          (req_i.addr),
        .patch_o         (sel_patch),
        .redirect_o      (redirect)
    );

    keystream_engine i_keystream_engine (
        .clk_core_slow_i (clk_core_slow_i),
        .rst_ni          (rst_ni),
        .load_i          (accept),
        .absorb_state_i  (absorb_state),
        .state_o         (engine_state),
        .busy_o          (engine_busy)
    );

    fetch_decryptor i_fetch_decryptor (
        .clk_core_slow_i (clk_core_slow_i),
        .rst_ni          (rst_ni),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .state_i         (engine_state),
        .busy_i          (engine_busy),
        .patch_i         (sel_patch),
        .redirect_i      (redirect),
        .accept_o        (accept),
        .absorb_state_o  (absorb_state)
    );

endmodule

// ==== verilog/ascon_round.sv ====
`timescale 1ns/1ps

module ascon_round (
    input  ascon_fetch_pkg::ascon_state_t state_i,
    input  logic [7:0]                    round_const_i,
    output ascon_fetch_pkg::ascon_state_t state_o
);
    import ascon_fetch_pkg::*;

    function automatic logic [LANE_WIDTH-1:0] rotr(
        input logic [LANE_WIDTH-1:0] x,
        input int unsigned           n
    );
        rotr = (x >> n) | (x << (LANE_WIDTH - n));
    endfunction

    logic [LANE_WIDTH-1:0] x0, x1, x2, x3, x4;
    logic [LANE_WIDTH-1:0] t0, t1, t2, t3, t4;

    always_comb begin
        x0 = state_i[0];
        x1 = state_i[1];
        // Constant addition on lane 2
        x2 = state_i[2] ^ {{(LANE_WIDTH-8){1'b0}}, round_const_i};
        x3 = state_i[3];
        x4 = state_i[4];

        // Bitsliced 5-bit S-box
        x0 = x0 ^ x4;
        x4 = x4 ^ x3;
        x2 = x2 ^ x1;

        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;

        x0 = x0 ^ t1;
        x1 = x1 ^ t2;
        x2 = x2 ^ t3;
        x3 = x3 ^ t4;
        x4 = x4 ^ t0;

        x1 = x1 ^ x0;
        x0 = x0 ^ x4;
        x3 = x3 ^ x2;
        x2 = ~x2;
    end

    // Linear diffusion with two rotations per lane
    assign state_o[0] = x0 ^ rotr(x0, 19) ^ rotr(x0, 28);
    assign state_o[1] = x1 ^ rotr(x1, 61) ^ rotr(x1, 39);
    assign state_o[2] = x2 ^ rotr(x2, 1) ^ rotr(x2, 6);
    assign state_o[3] = x3 ^ rotr(x3, 10) ^ rotr(x3, 17);
    assign state_o[4] = x4 ^ rotr(x4, 7) ^ rotr(x4, 41);

endmodule

// ==== verilog/fetch_decryptor.sv ====
`timescale 1ns/1ps

module fetch_decryptor (
    input  logic                          clk_core_slow_i,
    input  logic                          rst_ni,
    input  ascon_fetch_pkg::fetch_req_t   req_i,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    output ascon_fetch_pkg::fetch_rsp_t   rsp_o,
    output logic                          rsp_valid_o,
    input  logic                          rsp_ready_i,
    input  ascon_fetch_pkg::ascon_state_t state_i,
    input  logic                          busy_i,
    input  ascon_fetch_pkg::patch_t       patch_i,
    input  ascon_fetch_pkg::fetch_rsp_t   redirect_i,
    output logic                          accept_o,
    output ascon_fetch_pkg::ascon_state_t absorb_state_o
);
    import ascon_fetch_pkg::*;

    ascon_state_t          base_state;
    ascon_state_t          patched_state;
    logic [WORD_WIDTH-1:0] plain;
    fetch_rsp_t            rsp_d;
    fetch_rsp_t            rsp_q;
    logic                  rsp_valid_q;

    assign base_state    = req_i.init_state ? STATE_INIT : state_i;
    assign patched_state = req_i.apply_patch ? (base_state ^ patch_i) : base_state;

    // Keystream word is the upper half of lane 0
    assign plain = patched_state[0][LANE_WIDTH-1:LANE_WIDTH-WORD_WIDTH] ^ req_i.cipher;

    always_comb begin
        absorb_state_o = patched_state;
        absorb_state_o[0][LANE_WIDTH-1:LANE_WIDTH-WORD_WIDTH] = req_i.cipher;
    end

    always_comb begin
        rsp_d       = redirect_i;
        rsp_d.plain = plain;
    end

    assign req_ready_o = !busy_i && (!rsp_valid_q || rsp_ready_i);
    assign accept_o    = req_valid_i && req_ready_o;

    always_ff @(posedge clk_core_slow_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else if (accept_o) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_core_slow_i) begin
        if (accept_o) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = rsp_valid_q;

    a_rsp_stable: assert property (
        @(posedge clk_core_slow_i) disable iff (!rst_ni)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o)
    ) else $error("response changed under back-pressure");

endmodule

// ==== verilog/keystream_engine.sv ====
`timescale 1ns/1ps

module keystream_engine (
    input  logic                          clk_core_slow_i,
    input  logic                          rst_ni,
    input  logic                          load_i,
    input  ascon_fetch_pkg::ascon_state_t absorb_state_i,
    output ascon_fetch_pkg::ascon_state_t state_o,
    output logic                          busy_o
);
    import ascon_fetch_pkg::*;

    engine_state_e eng_state_q;
    logic [2:0]    rnd_cnt_q;
    ascon_state_t  state_q;
    ascon_state_t  round_state;

    ascon_round i_ascon_round (
        .state_i       (state_q),
        .round_const_i (ROUND_CONSTS[rnd_cnt_q]),
        .state_o       (round_state)
    );

    // One round per cycle after the absorbed state is loaded
    always_ff @(posedge clk_core_slow_i or negedge rst_ni) begin
        if (!rst_ni) begin
            eng_state_q <= ENG_IDLE;
            rnd_cnt_q   <= '0;
            state_q     <= STATE_INIT;
        end else begin
            case (eng_state_q)
                ENG_IDLE: begin
                    if (load_i) begin
                        state_q     <= absorb_state_i;
                        rnd_cnt_q   <= '0;
                        eng_state_q <= ENG_RUN;
                    end
                end
                ENG_RUN: begin
                    state_q <= round_state;
                    if (rnd_cnt_q == 3'(PB_ROUNDS - 1)) begin
                        rnd_cnt_q   <= '0;
                        eng_state_q <= ENG_IDLE;
                    end else begin
                        rnd_cnt_q <= rnd_cnt_q + 3'd1;
                    end
                end
                default: eng_state_q <= ENG_IDLE;
            endcase
        end
    end

    assign state_o = state_q;
    assign busy_o  = (eng_state_q == ENG_RUN);

    // The decryptor must hold off new fetches until the permutation is done
    a_no_load_when_busy: assert property (
        @(posedge clk_core_slow_i) disable iff (!rst_ni) busy_o |-> !load_i
    ) else $error("load while engine busy");

    a_round_cnt_range: assert property (
        @(posedge clk_core_slow_i) disable iff (!rst_ni) rnd_cnt_q < 3'(PB_ROUNDS)
    ) else $error("round counter out of range");

endmodule

// ==== verilog/patch_pipeline.sv ====
`timescale 1ns/1ps

module patch_pipeline (
    input  logic                                clk_core_slow_i,
    input  logic                                rst_ni,
    input  logic                                shift_i,
    input  ascon_fetch_pkg::patch_t             patch_i,
    input  ascon_fetch_pkg::patch_sel_e         sel_patch_i,
    input  logic [ascon_fetch_pkg::ADDR_WIDTH-1:0] addr_i,
    output ascon_fetch_pkg::patch_t             patch_o,
    output ascon_fetch_pkg::fetch_rsp_t         redirect_o
);
    import ascon_fetch_pkg::*;

    patch_t patch_if_q;
    patch_t patch_id_q;
    patch_t patch_ex_q;

    // Stages advance together with each accepted fetch
    always_ff @(posedge clk_core_slow_i or negedge rst_ni) begin
        if (!rst_ni) begin
            patch_if_q <= '0;
            patch_id_q <= '0;
            patch_ex_q <= '0;
        end else if (shift_i) begin
            patch_if_q <= patch_i;
            patch_id_q <= patch_if_q;
            patch_ex_q <= patch_id_q;
        end
    end

    always_comb begin
        case (sel_patch_i)
            PATCH_NULL: patch_o = '0;
            PATCH_IF:   patch_o = patch_if_q;
            PATCH_ID:   patch_o = patch_id_q;
            PATCH_EX:   patch_o = patch_ex_q;
            default:    patch_o = '0;
        endcase
    end

    // Walk from the top entry down so the lowest matching index wins
    always_comb begin
        redirect_o = '0;
        for (int i = NUM_REDIRECTS - 1; i >= 0; i--) begin
            if (patch_id_q.entries[i].src_word == addr_i[ADDR_WIDTH-1:2]) begin
                redirect_o.redirect_hit  = 1'b1;
                redirect_o.redirect_addr = {patch_id_q.entries[i].dst_word, 2'b00};
            end
        end
        redirect_o.redirect_tag = (patch_id_q.tag == REDIR_TAG);
    end

endmodule
